//--- Bender.yml
package:
  name: cop_coprocessor

export_include_dirs:
  - .

sources:
  - cop_pkg.sv
  - cop_cprs.sv
  - cop_alu.sv
  - cop_mem.sv
  - cop_ctrl.sv
  - cop_top.sv
  - target: test
    files:
      - cop_sva.sv
      - tb_cop_top.sv

//--- compile.f
+incdir+.
cop_pkg.sv
cop_cprs.sv
cop_alu.sv
cop_mem.sv
cop_ctrl.sv
cop_top.sv
cop_sva.sv
tb_cop_top.sv

//--- cop_alu.sv
// ----------------------------------------------------------------------
// Combinational word unit for cipher rounds. Operands come straight
// from the CPR read ports, the immediate from the held encoding.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cop_consts.svh"

module cop_alu (
    input  cop_pkg::cop_op_t   op,      // Opcode field
    input  cop_pkg::cop_word_t a,       // CPR crs1
    input  cop_pkg::cop_word_t b,       // CPR crs2
    input  cop_pkg::cop_word_t imm,     // Zero-extended immediate
    output cop_pkg::cop_word_t y
);

    logic [63:0] rot_dbl;               // Two copies of a for the rotate

    // Upper half of the shifted pair is a rotated left by b[4:0]
    assign rot_dbl = {a, a} << b[4:0];

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------
    always_comb begin
        case (op)
            `COP_OP_ADD: begin
                y = a + b;              // Wraps at 32 bits
            end
            `COP_OP_SUB: begin
                y = a - b;
            end
            `COP_OP_XOR: begin
                y = a ^ b;
            end
            `COP_OP_AND: begin
                y = a & b;
            end
            `COP_OP_ROTL: begin
                y = rot_dbl[63:32];
            end
            `COP_OP_LDI: begin
                y = imm;                // Immediate passes through
            end
            default: begin
                // Control never writes the result of a non-ALU code
                y = '0;
            end
        endcase
    end

endmodule

//--- cop_consts.svh
// ----------------------------------------------------------------------
// Instruction encoding of the coprocessor: field positions, opcodes
// and result codes. Include wherever the encoding is decoded.
// ----------------------------------------------------------------------
`ifndef COP_CONSTS_SVH
`define COP_CONSTS_SVH

`define COP_NCPRS       16          // Number of CPRs

// Field positions in the 32-bit encoding
`define COP_OP_HI       31
`define COP_OP_LO       28
`define COP_CRD_HI      27
`define COP_CRD_LO      24
`define COP_CRS1_HI     23
`define COP_CRS1_LO     20
`define COP_CRS2_HI     19
`define COP_CRS2_LO     16
`define COP_IMM_HI      15
`define COP_IMM_LO      0
`define COP_GPR_HI      4           // MVGPR destination only
`define COP_GPR_LO      0

// Opcodes with the ALU group first so that it stays contiguous
`define COP_OP_ADD      4'd0
`define COP_OP_SUB      4'd1
`define COP_OP_XOR      4'd2
`define COP_OP_AND      4'd3
`define COP_OP_ROTL     4'd4
`define COP_OP_LDI      4'd5
`define COP_OP_MVCOP    4'd6        // GPR rs1 into CPR
`define COP_OP_MVGPR    4'd7        // CPR into GPR
`define COP_OP_LW       4'd8
`define COP_OP_SW       4'd9        // Highest legal code

// Result codes
`define COP_RES_OK      3'd0
`define COP_RES_BAD_OP  3'd1
`define COP_RES_MEM_ERR 3'd2
`define COP_RES_ABORT   3'd3

`endif

//--- cop_cprs.sv
// ----------------------------------------------------------------------
// Coprocessor register file. Two asynchronous read ports and one
// synchronous write port, all registers cleared by reset.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cop_consts.svh"

module cop_cprs (
    input  logic                   g_clk,
    input  logic                   g_resetn,

    // Read ports
    input  cop_pkg::cop_cpr_addr_t rd_addr_a,
    input  cop_pkg::cop_cpr_addr_t rd_addr_b,
    output cop_pkg::cop_word_t     rd_data_a,
    output cop_pkg::cop_word_t     rd_data_b,

    // Write port
    input  logic                   wr_en,
    input  cop_pkg::cop_cpr_addr_t wr_addr,
    input  cop_pkg::cop_word_t     wr_data
);

    cop_pkg::cop_word_t regs [`COP_NCPRS];

    // Reads see the value before any write on the same edge
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NCPRS; i++) begin
                regs[i] <= '0;              // CPRs start at zero
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- cop_ctrl.sv
// ----------------------------------------------------------------------
// Control of the coprocessor. Accepts an instruction, decodes it,
// steps the execution FSM and drives the response handshake.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cop_consts.svh"

module cop_ctrl (
    input  logic                   g_clk,
    input  logic                   g_resetn,

    // CPU side
    input  logic                   cpu_insn_req,
    input  cop_pkg::cop_word_t     cpu_insn_enc,
    input  cop_pkg::cop_word_t     cpu_rs1,
    input  logic                   cpu_abort_req,
    input  logic                   cpu_insn_ack,    // Response taken
    output logic                   cop_insn_ack,    // Ready for request
    output logic                   cop_insn_rsp,
    output cop_pkg::cop_result_t   cop_result,
    output logic                   cop_wen,
    output cop_pkg::cop_gpr_addr_t cop_waddr,
    output cop_pkg::cop_word_t     cop_wdata,

    // CPRs and ALU
    output cop_pkg::cop_cpr_addr_t rd_addr_a,
    output cop_pkg::cop_cpr_addr_t rd_addr_b,
    input  cop_pkg::cop_word_t     rd_data_a,
    output cop_pkg::cop_op_t       alu_op,
    output cop_pkg::cop_word_t     alu_imm,
    input  cop_pkg::cop_word_t     alu_y,
    output logic                   cpr_wen,
    output cop_pkg::cop_cpr_addr_t cpr_waddr,
    output cop_pkg::cop_word_t     cpr_wdata,

    // Memory unit
    output logic                   mem_start,
    output logic                   mem_store,
    output cop_pkg::cop_word_t     mem_addr,
    output logic                   mem_abort,
    input  logic                   mem_done,
    input  logic                   mem_error,
    input  logic                   mem_aborted,
    input  cop_pkg::cop_word_t     mem_rdata
);

    cop_pkg::cop_state_e state;
    cop_pkg::cop_word_t  enc_q;         // Held encoding
    cop_pkg::cop_word_t  rs1_q;         // Held rs1
    cop_pkg::cop_word_t  ea;            // rs1 plus immediate
    cop_pkg::cop_op_t    op;
    logic                legal, is_alu, is_mem, is_mvcop, is_mvgpr;

    assign cop_insn_ack = (state == cop_pkg::IDLE);
    assign cop_insn_rsp = (state == cop_pkg::RESP);

    // ------------------------------------------------------------------
    // Decode of the held fields
    // ------------------------------------------------------------------
    assign op       = enc_q[`COP_OP_HI:`COP_OP_LO];
    assign legal    = (op <= `COP_OP_SW);
    assign is_alu   = (op <= `COP_OP_LDI);              // ADD up to LDI
    assign is_mvcop = (op == `COP_OP_MVCOP);
    assign is_mvgpr = (op == `COP_OP_MVGPR);
    assign is_mem   = (op == `COP_OP_LW) || (op == `COP_OP_SW);

    assign rd_addr_a = enc_q[`COP_CRS1_HI:`COP_CRS1_LO];
    assign rd_addr_b = enc_q[`COP_CRS2_HI:`COP_CRS2_LO];   // Also SW data
    assign alu_op    = op;
    assign alu_imm   = {16'h0000, enc_q[`COP_IMM_HI:`COP_IMM_LO]};

    // Word address with the low bits dropped
    assign ea        = rs1_q + alu_imm;
    assign mem_addr  = {ea[31:2], 2'b00};
    assign mem_store = (op == `COP_OP_SW);
    assign mem_start = (state == cop_pkg::EXEC) && is_mem;
    assign mem_abort = (state == cop_pkg::MEM) && cpu_abort_req;

    // CPR write in EXEC, or for a clean load when memory finishes
    assign cpr_waddr = enc_q[`COP_CRD_HI:`COP_CRD_LO];
    assign cpr_wen   = ((state == cop_pkg::EXEC) && (is_alu || is_mvcop))
                     || ((state == cop_pkg::MEM) && mem_done && !mem_store
                         && !mem_error && !mem_aborted);
    assign cpr_wdata = (state == cop_pkg::MEM) ? mem_rdata :
                       is_mvcop                ? rs1_q     : alu_y;

    // ------------------------------------------------------------------
    // Execution FSM
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state      <= cop_pkg::IDLE;
            cop_result <= `COP_RES_OK;
            cop_wen    <= 1'b0;
        end else begin
            case (state)
                cop_pkg::IDLE: begin
                    if (cpu_insn_req) state <= cop_pkg::EXEC;  // Accept edge
                end
                cop_pkg::EXEC: begin
                    if (is_mem) begin
                        state <= cop_pkg::MEM;
                    end else begin
                        state      <= cop_pkg::RESP;
                        cop_result <= legal ? `COP_RES_OK : `COP_RES_BAD_OP;
                        cop_wen    <= is_mvgpr;
                    end
                end
                cop_pkg::MEM: begin
                    if (mem_done) begin
                        state      <= cop_pkg::RESP;
                        cop_wen    <= 1'b0;
                        cop_result <= mem_aborted ? `COP_RES_ABORT   :
                                      mem_error   ? `COP_RES_MEM_ERR : `COP_RES_OK;
                    end
                end
                default: begin
                    if (cpu_insn_ack) state <= cop_pkg::IDLE;  // RESP done
                end
            endcase
        end
    end

    // Instruction capture and GPR write payload
    always_ff @(posedge g_clk) begin
        if (cpu_insn_req && cop_insn_ack) begin
            enc_q <= cpu_insn_enc;
            rs1_q <= cpu_rs1;
        end
        if (state == cop_pkg::EXEC) begin
            cop_waddr <= is_mvgpr ? enc_q[`COP_GPR_HI:`COP_GPR_LO] : '0;
            cop_wdata <= is_mvgpr ? rd_data_a : '0;
        end
    end

endmodule

//--- cop_mem.sv
// ----------------------------------------------------------------------
// Load/store sequencer. Takes one request on start, holds the memory
// port through stalls and reports completion, error or abort.
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cop_mem (
    input  logic               g_clk,
    input  logic               g_resetn,

    // Request from control
    input  logic               start,           // One-cycle request
    input  logic               store,           // 1 for SW
    input  cop_pkg::cop_word_t addr,            // Already word aligned
    input  cop_pkg::cop_word_t wdata,
    input  logic               abort,           // Only in MEM state

    // Result to control
    output logic               done,            // One-cycle pulse
    output logic               error,
    output logic               aborted,
    output cop_pkg::cop_word_t rdata_q,

    // Memory port
    output logic               cop_mem_cen,
    output logic               cop_mem_wen,
    output cop_pkg::cop_word_t cop_mem_addr,
    output cop_pkg::cop_word_t cop_mem_wdata,
    output logic [3:0]         cop_mem_ben,
    input  cop_pkg::cop_word_t cop_mem_rdata,
    input  logic               cop_mem_stall,
    input  logic               cop_mem_error
);

    logic finish;                       // Access completes this edge

    assign finish      = cop_mem_cen && !cop_mem_stall && !abort;
    assign cop_mem_ben = {4{cop_mem_wen}};   // Whole word on stores

    // ------------------------------------------------------------------
    // Port control and status flags
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_mem_cen <= 1'b0;
            cop_mem_wen <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
            aborted     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cop_mem_cen <= 1'b1;
                cop_mem_wen <= store;
                error       <= 1'b0;
                aborted     <= 1'b0;
            end else if (cop_mem_cen && abort) begin
                // Abort wins over a completing edge
                cop_mem_cen <= 1'b0;
                cop_mem_wen <= 1'b0;
                done        <= 1'b1;
                aborted     <= 1'b1;
            end else if (finish) begin
                cop_mem_cen <= 1'b0;
                cop_mem_wen <= 1'b0;
                done        <= 1'b1;
                error       <= cop_mem_error;   // Sampled with the data
            end
        end
    end

    // Held request and returned load data
    always_ff @(posedge g_clk) begin
        if (start) begin
            cop_mem_addr  <= addr;
            cop_mem_wdata <= wdata;
        end
        if (finish) begin
            rdata_q <= cop_mem_rdata;
        end
    end

endmodule

//--- cop_pkg.sv
// ----------------------------------------------------------------------
// Shared types of the coprocessor. Referenced by scoped names from
// every design unit, never imported.
// ----------------------------------------------------------------------
package cop_pkg;

    // Data word for CPR values, rs1, memory data and addresses
    typedef logic [31:0] cop_word_t;

    typedef logic [3:0]  cop_cpr_addr_t;   // CPR index
    typedef logic [4:0]  cop_gpr_addr_t;   // CPU destination register
    typedef logic [2:0]  cop_result_t;     // Result code to the CPU
    typedef logic [3:0]  cop_op_t;         // Opcode field

    // ------------------------------------------------------------------
    // Control FSM states
    // IDLE   waiting for a request, ack high
    // EXEC   one cycle of decode and register update
    // MEM    memory access in flight
    // RESP   response held until the CPU acknowledges
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1,
        MEM  = 2'd2,
        RESP = 2'd3
    } cop_state_e;

endpackage

//--- cop_sva.sv
// ----------------------------------------------------------------------
// Handshake and reset assertions, bound to the coprocessor top level
// from the testbench.
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cop_sva (
    input logic                   g_clk,
    input logic                   g_resetn,
    input logic                   cpu_insn_req,
    input cop_pkg::cop_word_t     cpu_insn_enc,
    input cop_pkg::cop_word_t     cpu_rs1,
    input logic                   cpu_abort_req,
    input logic                   cop_insn_ack,
    input logic                   cpu_insn_ack,
    input logic                   cop_insn_rsp,
    input cop_pkg::cop_result_t   cop_result,
    input logic                   cop_wen,
    input cop_pkg::cop_gpr_addr_t cop_waddr,
    input cop_pkg::cop_word_t     cop_wdata,
    input logic                   cop_mem_cen,
    input logic                   cop_mem_wen,
    input cop_pkg::cop_word_t     cop_mem_addr,
    input cop_pkg::cop_word_t     cop_mem_wdata,
    input logic                   cop_mem_stall
);

    // CPU holds a pending request
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cpu_insn_req && !cop_insn_ack |=>
            cpu_insn_req && $stable(cpu_insn_enc) && $stable(cpu_rs1))
        else $error("request changed before it was accepted");

    // Response held until the CPU takes it
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=>
            cop_insn_rsp && $stable(cop_result) && $stable(cop_wen)
            && $stable(cop_waddr) && $stable(cop_wdata))
        else $error("response changed before cpu_insn_ack");

    assert property (@(posedge g_clk)
        !g_resetn |=> !cop_insn_rsp && !cop_wen && !cop_mem_cen && !cop_mem_wen)
        else $error("control output high after a reset cycle");

    // Stalled memory request held unless aborted
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_mem_cen && cop_mem_stall && !cpu_abort_req |=>
            cop_mem_cen && $stable(cop_mem_wen) && $stable(cop_mem_addr)
            && $stable(cop_mem_wdata))
        else $error("memory request changed during a stall");

endmodule

//--- cop_top.sv
// ----------------------------------------------------------------------
// Coprocessor top level. Connects control, CPRs, word unit and the
// load/store sequencer to the CPU and memory ports.
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cop_top (
    input  logic                   g_clk,
    input  logic                   g_resetn,

    // Instruction request and response
    input  logic                   cpu_insn_req,
    output logic                   cop_insn_ack,
    input  logic                   cpu_abort_req,
    input  cop_pkg::cop_word_t     cpu_insn_enc,
    input  cop_pkg::cop_word_t     cpu_rs1,
    output logic                   cop_wen,
    output cop_pkg::cop_gpr_addr_t cop_waddr,
    output cop_pkg::cop_word_t     cop_wdata,
    output cop_pkg::cop_result_t   cop_result,
    output logic                   cop_insn_rsp,
    input  logic                   cpu_insn_ack,

    // Memory port
    output logic                   cop_mem_cen,
    output logic                   cop_mem_wen,
    output cop_pkg::cop_word_t     cop_mem_addr,
    output cop_pkg::cop_word_t     cop_mem_wdata,
    input  cop_pkg::cop_word_t     cop_mem_rdata,
    output logic [3:0]             cop_mem_ben,
    input  logic                   cop_mem_stall,
    input  logic                   cop_mem_error
);

    cop_pkg::cop_cpr_addr_t rd_addr_a, rd_addr_b, cpr_waddr;
    cop_pkg::cop_word_t     rd_data_a, rd_data_b, cpr_wdata;
    cop_pkg::cop_op_t       alu_op;
    cop_pkg::cop_word_t     alu_imm, alu_y, mem_addr, mem_rdata;
    logic                   cpr_wen, mem_start, mem_store, mem_abort;
    logic                   mem_done, mem_error, mem_aborted;

    cop_ctrl u_ctrl (
        .g_clk, .g_resetn,
        .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_abort_req, .cpu_insn_ack,
        .cop_insn_ack, .cop_insn_rsp, .cop_result, .cop_wen, .cop_waddr,
        .cop_wdata,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .alu_op, .alu_imm, .alu_y,
        .cpr_wen, .cpr_waddr, .cpr_wdata,
        .mem_start, .mem_store, .mem_addr, .mem_abort,
        .mem_done, .mem_error, .mem_aborted, .mem_rdata
    );

    cop_cprs u_cprs (
        .g_clk, .g_resetn,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_en   (cpr_wen),
        .wr_addr (cpr_waddr),
        .wr_data (cpr_wdata)
    );

    // Word unit fed straight from the read ports
    cop_alu u_alu (
        .op  (alu_op),
        .a   (rd_data_a),
        .b   (rd_data_b),
        .imm (alu_imm),
        .y   (alu_y)
    );

    // Store data is CPR crs2
    cop_mem u_mem (
        .g_clk, .g_resetn,
        .start   (mem_start),
        .store   (mem_store),
        .addr    (mem_addr),
        .wdata   (rd_data_b),
        .abort   (mem_abort),
        .done    (mem_done),
        .error   (mem_error),
        .aborted (mem_aborted),
        .rdata_q (mem_rdata),
        .cop_mem_cen, .cop_mem_wen, .cop_mem_addr, .cop_mem_wdata,
        .cop_mem_ben, .cop_mem_rdata, .cop_mem_stall, .cop_mem_error
    );

endmodule

//--- tb_cop_top.sv
// ----------------------------------------------------------------------
// Testbench of the coprocessor. Runs a table of instructions through
// the CPU handshake against a stalling memory model and checks each
// response that the transaction monitor captures.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cop_consts.svh"

module tb_cop_top;

    localparam logic [31:0] VAL_A = 32'h8bad_f00d;
    localparam logic [31:0] VAL_B = 32'h1234_56ed;    // Low five bits are 13

    logic                   g_clk, g_resetn;
    logic                   cpu_insn_req, cpu_abort_req, cpu_insn_ack;
    cop_pkg::cop_word_t     cpu_insn_enc, cpu_rs1;
    logic                   cop_insn_ack, cop_insn_rsp, cop_wen;
    cop_pkg::cop_result_t   cop_result;
    cop_pkg::cop_gpr_addr_t cop_waddr;
    cop_pkg::cop_word_t     cop_wdata;
    logic                   cop_mem_cen, cop_mem_wen, cop_mem_stall, cop_mem_error;
    logic [3:0]             cop_mem_ben;
    cop_pkg::cop_word_t     cop_mem_addr, cop_mem_wdata, cop_mem_rdata;

    // Stimulus table with one slot per instruction
    string                  t_name[$];
    cop_pkg::cop_word_t     t_enc[$], t_rs1[$], t_wdata[$];
    logic                   t_abort[$], t_wen[$];
    cop_pkg::cop_result_t   t_res[$];
    cop_pkg::cop_gpr_addr_t t_waddr[$];

    cop_pkg::cop_word_t     mem [64];                 // Memory model
    logic [255:0]           stall_bits;               // Random stall pattern
    logic                   stall_q, hold_stall;      // hold_stall pins stall for aborts
    int                     cycles = 0;
    int                     limit = 0;
    int                     n_checks = 0;
    int                     n_errors = 0;
    int                     n_rsp = 0;

    // Monitor captures
    cop_pkg::cop_word_t     mon_enc, mon_wdata;
    cop_pkg::cop_result_t   mon_result;
    logic                   mon_wen;
    cop_pkg::cop_gpr_addr_t mon_waddr;

    cop_top i_dut (.*);

    bind cop_top cop_sva i_sva (.*);

    always #2 g_clk = ~g_clk;

    // ------------------------------------------------------------------
    // Timeout and memory model
    // ------------------------------------------------------------------
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: no response within %0d cycles", limit);
            $display("Checks: %0d, errors: %0d", n_checks, n_errors);
            $display("Verification failed");
            $finish;
        end
    end

    assign cop_mem_stall = hold_stall || stall_q;
    assign cop_mem_rdata = mem[cop_mem_addr[7:2]];
    assign cop_mem_error = cop_mem_cen && (cop_mem_addr[31:2] >= 60);   // Top words fault

    always @(posedge g_clk) begin
        #0.5;
        stall_q = stall_bits[cycles[7:0]];
    end

    // Store per byte lane on the completing edge
    always @(posedge g_clk) begin
        if (cop_mem_cen && !cop_mem_stall && cop_mem_wen && !cop_mem_error) begin
            for (int b = 0; b < 4; b++) begin
                if (cop_mem_ben[b]) mem[cop_mem_addr[7:2]][8*b +: 8] <= cop_mem_wdata[8*b +: 8];
            end
        end
    end

    // Transaction monitor on the accept and completion edges
    always @(posedge g_clk) begin
        if (g_resetn && cpu_insn_req && cop_insn_ack) mon_enc <= cpu_insn_enc;
        if (g_resetn && cop_insn_rsp && cpu_insn_ack) begin
            mon_result <= cop_result;
            mon_wen    <= cop_wen;
            mon_waddr  <= cop_waddr;
            mon_wdata  <= cop_wdata;
            n_rsp      <= n_rsp + 1;
        end
    end

    // ------------------------------------------------------------------
    // Reference helpers
    // ------------------------------------------------------------------
    function automatic cop_pkg::cop_word_t encode(input int op, crd, crs1, crs2, imm);
        return {op[3:0], crd[3:0], crs1[3:0], crs2[3:0], imm[15:0]};
    endfunction

    function automatic cop_pkg::cop_word_t rotl(input logic [31:0] x, input logic [4:0] n);
        logic [31:0] r;
        r = x;
        for (int k = 0; k < n; k++) r = {r[30:0], r[31]};    // One bit per step
        return r;
    endfunction

    function automatic cop_pkg::cop_word_t fill_word(input logic [31:0] w);
        return (w * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", what, exp, act);
        end
    endtask

    task automatic add_entry(input string name, input logic [31:0] enc, rs1,
                             input logic abort, input logic [2:0] res, input logic wen,
                             input logic [4:0] waddr, input logic [31:0] wdata);
        t_name.push_back(name);
        t_enc.push_back(enc);
        t_rs1.push_back(rs1);
        t_abort.push_back(abort);
        t_res.push_back(res);
        t_wen.push_back(wen);
        t_waddr.push_back(waddr);
        t_wdata.push_back(wdata);
    endtask

    // No GPR write expected
    task automatic add_op(input string name, input logic [31:0] enc, rs1, input logic [2:0] res);
        add_entry(name, enc, rs1, 1'b0, res, 1'b0, '0, '0);
    endtask

    // MVGPR read back of one CPR
    task automatic add_read(input string name, input int cpr, input logic [31:0] value);
        logic [4:0] gpr;
        gpr = 5'(cpr) + 5'd1;
        add_entry(name, encode(`COP_OP_MVGPR, 0, cpr, 0, gpr), '0, 1'b0, `COP_RES_OK,
                  1'b1, gpr, value);
    endtask

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------
    task automatic build_table();
        add_read("reset_c0", 0, 32'h0);
        add_read("reset_c7", 7, 32'h0);
        add_read("reset_c15", 15, 32'h0);
        add_op("mvcop_c1", encode(`COP_OP_MVCOP, 1, 0, 0, 0), VAL_A, `COP_RES_OK);
        add_op("mvcop_c2", encode(`COP_OP_MVCOP, 2, 0, 0, 0), VAL_B, `COP_RES_OK);
        add_read("mvgpr_c1", 1, VAL_A);
        add_op("ldi_c3", encode(`COP_OP_LDI, 3, 0, 0, 'hbeef), 0, `COP_RES_OK);
        add_read("mvgpr_c3", 3, 32'h0000_beef);             // Zero extended
        add_op("add_c4", encode(`COP_OP_ADD, 4, 1, 2, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c4", 4, VAL_A + VAL_B);
        add_op("sub_c5", encode(`COP_OP_SUB, 5, 1, 2, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c5", 5, VAL_A - VAL_B);
        add_op("xor_c6", encode(`COP_OP_XOR, 6, 1, 2, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c6", 6, VAL_A ^ VAL_B);
        add_op("and_c7", encode(`COP_OP_AND, 7, 1, 2, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c7", 7, VAL_A & VAL_B);
        add_op("rotl_c8", encode(`COP_OP_ROTL, 8, 1, 2, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c8", 8, rotl(VAL_A, VAL_B[4:0]));
        add_op("rotl_zero", encode(`COP_OP_ROTL, 12, 1, 0, 0), 0, `COP_RES_OK);
        add_read("mvgpr_c12", 12, VAL_A);
        // 0x13 plus 2 aligns down to word 5
        add_op("sw_w5", encode(`COP_OP_SW, 0, 0, 1, 'h2), 32'h13, `COP_RES_OK);
        add_op("lw_w5", encode(`COP_OP_LW, 9, 0, 0, 'h4), 32'h10, `COP_RES_OK);
        add_read("mvgpr_c9", 9, VAL_A);
        add_op("lw_w20", encode(`COP_OP_LW, 10, 0, 0, 'h50), 0, `COP_RES_OK);
        add_read("mvgpr_c10", 10, fill_word(20));
        add_op("sw_w30", encode(`COP_OP_SW, 0, 0, 2, 'h8), 32'h70, `COP_RES_OK);
        add_op("lw_w30", encode(`COP_OP_LW, 13, 0, 0, 'h8), 32'h70, `COP_RES_OK);
        add_read("mvgpr_c13", 13, VAL_B);
        add_op("lw_err_w60", encode(`COP_OP_LW, 4, 0, 0, 0), 32'hf0, `COP_RES_MEM_ERR);
        add_op("lw_err_far", encode(`COP_OP_LW, 4, 0, 0, 'h10), 32'h1_0000, `COP_RES_MEM_ERR);
        add_op("sw_err_w63", encode(`COP_OP_SW, 0, 0, 1, 'hfc), 0, `COP_RES_MEM_ERR);
        add_read("mvgpr_c4_kept", 4, VAL_A + VAL_B);
        for (int op = 10; op < 16; op++) begin
            add_op($sformatf("bad_op_%0d", op), encode(op, 1, 2, 3, 'hffff), VAL_B,
                   `COP_RES_BAD_OP);
        end
        add_read("mvgpr_c1_kept", 1, VAL_A);
        add_entry("lw_abort", encode(`COP_OP_LW, 2, 0, 0, 'h14), 0, 1'b1, `COP_RES_ABORT,
                  1'b0, '0, '0);
        add_read("mvgpr_c2_kept", 2, VAL_B);
    endtask

    // ------------------------------------------------------------------
    // CPU driver for one table entry
    // ------------------------------------------------------------------
    task automatic run_entry(input int i);
        int          lat;
        int          delay;
        logic [41:0] held;
        check_value({t_name[i], " ready"}, 1, cop_insn_ack);
        cpu_insn_req  = 1'b1;
        cpu_insn_enc  = t_enc[i];
        cpu_rs1       = t_rs1[i];
        cpu_abort_req = t_abort[i];
        hold_stall    = t_abort[i];
        lat = 0;
        do begin
            @(posedge g_clk);
            #0.5;
            lat++;
            if (!cop_insn_ack) cpu_insn_req = 1'b0;    // Taken on the last edge
        end while (!cop_insn_rsp);
        if (t_enc[i][`COP_OP_HI:`COP_OP_LO] != `COP_OP_LW
                && t_enc[i][`COP_OP_HI:`COP_OP_LO] != `COP_OP_SW) begin
            check_value({t_name[i], " latency"}, 2, lat);
        end
        // Next request waits while the response is held back
        if (i + 1 < t_name.size()) begin
            cpu_insn_req = 1'b1;
            cpu_insn_enc = t_enc[i+1];
            cpu_rs1      = t_rs1[i+1];
        end
        // Withhold the ack for a while so that the response must hold
        held  = {cop_insn_rsp, cop_result, cop_wen, cop_waddr, cop_wdata};
        delay = $urandom % 4;
        repeat (delay) begin
            @(posedge g_clk);
            #0.5;
            check_value({t_name[i], " ack while busy"}, 0, cop_insn_ack);
            check_value({t_name[i], " held response"}, held,
                        {cop_insn_rsp, cop_result, cop_wen, cop_waddr, cop_wdata});
        end
        cpu_insn_ack = 1'b1;
        @(posedge g_clk);
        #0.5;
        cpu_insn_ack  = 1'b0;
        cpu_abort_req = 1'b0;
        hold_stall    = 1'b0;
        check_value({t_name[i], " encoding"}, t_enc[i], mon_enc);
        check_value({t_name[i], " result"}, t_res[i], mon_result);
        check_value({t_name[i], " wen"}, t_wen[i], mon_wen);
        if (t_wen[i]) begin
            check_value({t_name[i], " waddr"}, t_waddr[i], mon_waddr);
            check_value({t_name[i], " wdata"}, t_wdata[i], mon_wdata);
        end
    endtask

    initial begin
        void'($urandom(52));
        g_clk         = 1'b0;
        g_resetn      = 1'b0;
        cpu_insn_req  = 1'b0;
        cpu_insn_enc  = '0;
        cpu_rs1       = '0;
        cpu_abort_req = 1'b0;
        cpu_insn_ack  = 1'b0;
        stall_q       = 1'b0;
        hold_stall    = 1'b0;
        for (int k = 0; k < 8; k++) stall_bits[32*k +: 32] = $urandom;
        for (int w = 0; w < 64; w++) mem[w] = fill_word(w);
        build_table();
        limit = t_name.size() * 40 + 8;
        repeat (8) @(posedge g_clk);
        #0.5;
        g_resetn = 1'b1;
        check_value("reset ack", 1, cop_insn_ack);
        check_value("reset rsp", 0, cop_insn_rsp);
        check_value("reset wen", 0, cop_wen);
        check_value("reset cen", 0, cop_mem_cen);
        for (int i = 0; i < t_name.size(); i++) run_entry(i);
        check_value("response count", t_name.size(), n_rsp);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
